//--- sim.f
src/isaPkg.sv
src/ctrlPkg.sv
src/ctrlDecoder.sv
src/nextPc.sv
src/memLaneUnit.sv
src/mulDivUnit.sv
src/decodeExecute.sv
testbench/decodeExecuteTb.sv

//--- testbench/decodeStim.txt
// wait instr pc rsData rtData addrLow memRdata | expected: regWrite memWrite
// nextPcOut byteEnable loadData hi lo mduResult (hex except wait, wait>0 = MDU cycles)
// ALU, immediate and unknown instructions
0 00221820 1000 5 6 0 0 1 0 1004 0 0 0 0 0
0 00221822 1000 5 6 0 0 1 0 1004 0 0 0 0 0
0 00221824 1000 5 6 0 0 1 0 1004 0 0 0 0 0
0 00221825 1000 5 6 0 0 1 0 1004 0 0 0 0 0
0 0022182A 1000 5 6 0 0 1 0 1004 0 0 0 0 0
0 0022182B 1000 5 6 0 0 1 0 1004 0 0 0 0 0
0 20220010 1000 5 6 0 0 1 0 1004 0 0 0 0 0
0 30220010 1000 5 6 0 0 1 0 1004 0 0 0 0 0
0 34220010 1000 5 6 0 0 1 0 1004 0 0 0 0 0
0 3C020010 1000 5 6 0 0 1 0 1004 0 0 0 0 0
0 FC221820 1000 5 6 0 0 0 0 1004 0 0 0 0 0
0 0022183F 1000 5 6 0 0 0 0 1004 0 0 0 0 0
// Branches and jumps
0 10220010 1000 5 5 0 0 0 0 1044 0 0 0 0 0
0 10220010 1000 5 6 0 0 0 0 1004 0 0 0 0 0
0 1422FFFC 1000 5 6 0 0 0 0 0FF4 0 0 0 0 0
0 1422FFFC 1000 7 7 0 0 0 0 1004 0 0 0 0 0
0 08000400 90000100 0 0 0 0 0 0 90001000 0 0 0 0 0
0 0C123456 1000 0 0 0 0 1 0 0048D158 0 0 0 0 0
0 00200008 1000 ABCC 0 0 0 0 0 ABCC 0 0 0 0 0
// Stores sw, sh, sb
0 AC220000 1000 0 0 0 0 0 1 1004 F 0 0 0 0
0 A4220000 1000 0 0 0 0 0 1 1004 3 0 0 0 0
0 A4220000 1000 0 0 1 0 0 1 1004 3 0 0 0 0
0 A4220000 1000 0 0 2 0 0 1 1004 C 0 0 0 0
0 A4220000 1000 0 0 3 0 0 1 1004 C 0 0 0 0
0 A0220000 1000 0 0 0 0 0 1 1004 1 0 0 0 0
0 A0220000 1000 0 0 1 0 0 1 1004 2 0 0 0 0
0 A0220000 1000 0 0 2 0 0 1 1004 4 0 0 0 0
0 A0220000 1000 0 0 3 0 0 1 1004 8 0 0 0 0
// Loads lw, lb, lh, lhs
0 8C220000 1000 0 0 0 80F17F2A 1 0 1004 0 80F17F2A 0 0 0
0 80220000 1000 0 0 0 80F17F2A 1 0 1004 0 0000002A 0 0 0
0 80220000 1000 0 0 1 80F17F2A 1 0 1004 0 0000007F 0 0 0
0 80220000 1000 0 0 2 80F17F2A 1 0 1004 0 FFFFFFF1 0 0 0
0 80220000 1000 0 0 3 80F17F2A 1 0 1004 0 FFFFFF80 0 0 0
0 84220000 1000 0 0 0 80F17F2A 1 0 1004 0 00007F2A 0 0 0
0 84220000 1000 0 0 1 80F17F2A 1 0 1004 0 00007F2A 0 0 0
0 84220000 1000 0 0 2 80F17F2A 1 0 1004 0 FFFF80F1 0 0 0
0 84220000 1000 0 0 3 80F17F2A 1 0 1004 0 FFFF80F1 0 0 0
0 90220000 1000 0 0 0 80F17F2A 1 0 1004 0 00007F2A 0 0 0
0 90220000 1000 0 0 1 80F17F2A 0 0 1004 0 00007F2A 0 0 0
0 90220000 1000 0 0 2 80F17F2A 1 0 1004 0 FFFF80F1 0 0 0
0 90220000 1000 0 0 3 80F17F2A 0 0 1004 0 FFFF80F1 0 0 0
// Multiply and divide, hi lo are the results after busy falls
5 00220018 1000 FFFFFFFE 3 0 0 0 0 1004 0 0 FFFFFFFF FFFFFFFA 0
5 00220019 1000 FFFFFFFE 3 0 0 0 0 1004 0 0 00000002 FFFFFFFA 0
10 0022001A 1000 FFFFFFF9 2 0 0 0 0 1004 0 0 FFFFFFFF FFFFFFFD 0
10 0022001B 1000 64 7 0 0 0 0 1004 0 0 00000002 0000000E 0
10 0022001A 1000 12345678 0 0 0 0 0 1004 0 0 12345678 FFFFFFFF 0
10 0022001B 1000 FFFFFF00 0 0 0 0 0 1004 0 0 FFFFFF00 FFFFFFFF 0
// mthi, mtlo, then mfhi, mflo
0 00200011 1000 CAFE0001 0 0 0 0 0 1004 0 0 FFFFFF00 FFFFFFFF 0
0 00200013 1000 BEEF0002 0 0 0 0 0 1004 0 0 CAFE0001 FFFFFFFF 0
0 00001810 1000 0 0 0 0 1 0 1004 0 0 CAFE0001 BEEF0002 CAFE0001
0 00001812 1000 0 0 0 0 1 0 1004 0 0 CAFE0001 BEEF0002 BEEF0002

//--- testbench/decodeExecuteTb.sv
`timescale 1ns/1ps

module decodeExecuteTb;

	localparam int clkPeriod   = 4;
	localparam int driveDelay  = 1;
	localparam int checkDelay  = 2; // 1 ns before the next edge
	localparam int resetCycles = 10;
	localparam int divCycles   = 10; // DUT default
	localparam int numFields   = 15;

	// One line of the stimulus file
	typedef struct packed {
		logic [31:0] waitCount;
		logic [31:0] instr;
		logic [31:0] pc;
		logic [31:0] rsData;
		logic [31:0] rtData;
		logic [1:0]  addrLow;
		logic [31:0] memRdata;
		logic        regWrite;
		logic        memWrite;
		logic [31:0] nextPcOut;
		logic [3:0]  byteEnable;
		logic [31:0] loadData;
		logic [31:0] hi;
		logic [31:0] lo;
		logic [31:0] mduResult;
	} testVector;

	logic               clk;
	logic               reset;
	isaPkg::instrWord   instr;
	logic [31:0]        pc;
	logic [31:0]        rsData;
	logic [31:0]        rtData;
	logic [1:0]         addrLow;
	logic [31:0]        memRdata;
	ctrlPkg::ctrlBundle ctrl;
	logic [31:0]        nextPcOut;
	logic [3:0]         byteEnable;
	logic [31:0]        loadData;
	logic [31:0]        hi;
	logic [31:0]        lo;
	logic [31:0]        mduResult;
	logic               mduBusy;

	testVector vectors[$];
	int        mismatchCount = 0;
	int        failureCount  = 0;
	logic      vectorsLoaded = 1'b0;

	decodeExecute dut0 (
		.clk       (clk),
		.reset     (reset),
		.instr     (instr),
		.pc        (pc),
		.rsData    (rsData),
		.rtData    (rtData),
		.addrLow   (addrLow),
		.memRdata  (memRdata),
		.ctrl      (ctrl),
		.nextPcOut (nextPcOut),
		.byteEnable(byteEnable),
		.loadData  (loadData),
		.hi        (hi),
		.lo        (lo),
		.mduResult (mduResult),
		.mduBusy   (mduBusy)
	);

	always #(clkPeriod / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////
	task automatic compareSignal(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual === expected) else begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
			mismatchCount++;
		end
	endtask

	task automatic readVectors();
		int                 fd;
		int                 code;
		logic [8*200-1:0]   skipBuf;
		logic [31:0]        f [0:numFields-1];
		testVector          v;
		fd = $fopen("testbench/decodeStim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file testbench/decodeStim.txt");
			failureCount++;
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
					f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
				if (code == numFields) begin
					v = {f[0], f[1], f[2], f[3], f[4], f[5][1:0], f[6], f[7][0],
						f[8][0], f[9], f[10][3:0], f[11], f[12], f[13], f[14]};
					vectors.push_back(v);
				end else if (!$feof(fd)) begin
					if (code > 0) begin
						$display("stimulus line with only %0d fields was skipped", code);
						failureCount++;
					end
					code = $fgets(skipBuf, fd); // Rest of a comment line
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic waitMduIdle(input int limit, output int cycles);
		cycles = 0;
		while (mduBusy && cycles < limit) begin
			@(posedge clk);
			#driveDelay;
			cycles++;
		end
		assert (!mduBusy) else begin
			$display("MDU still busy after %0d cycles at %0t", cycles, $time);
			failureCount++;
		end
	endtask

	task automatic applyVector(input testVector v);
		int busyCycles;
		@(posedge clk);
		#driveDelay;
		instr    = v.instr;
		pc       = v.pc;
		rsData   = v.rsData;
		rtData   = v.rtData;
		addrLow  = v.addrLow;
		memRdata = v.memRdata;
		#checkDelay;
		compareSignal("regWrite", ctrl.regWrite, v.regWrite);
		compareSignal("memWrite", ctrl.memWrite, v.memWrite);
		compareSignal("nextPcOut", nextPcOut, v.nextPcOut);
		compareSignal("byteEnable", byteEnable, v.byteEnable);
		compareSignal("loadData", loadData, v.loadData);
		compareSignal("mduResult", mduResult, v.mduResult);
		if (v.waitCount == 0) begin
			compareSignal("hi", hi, v.hi);
			compareSignal("lo", lo, v.lo);
		end else begin
			// Start taken on this edge
			@(posedge clk);
			#driveDelay;
			assert (mduBusy === 1'b1) else begin
				$display("MDU did not go busy after the start at %0t", $time);
				failureCount++;
			end
			instr = '0; // Nop while the unit works
			waitMduIdle(v.waitCount + 2, busyCycles);
			compareSignal("busy cycles", busyCycles, v.waitCount);
			compareSignal("hi", hi, v.hi);
			compareSignal("lo", lo, v.lo);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		$timeformat(-9, 0, " ns", 0);
		clk      = 1'b0;
		reset    = 1'b1;
		instr    = '0;
		pc       = '0;
		rsData   = '0;
		rtData   = '0;
		addrLow  = '0;
		memRdata = '0;
		readVectors();
		vectorsLoaded = 1'b1;
		if (vectors.size() == 0) begin
			$display("no test vectors were read from the stimulus file");
			failureCount++;
		end
		repeat (resetCycles) @(posedge clk);
		#driveDelay reset = 1'b0;
		foreach (vectors[i])
			applyVector(vectors[i]);
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
		if (mismatchCount + failureCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Worst case per vector is one divide plus margin
	initial begin : watchdog
		int timeoutCycles;
		wait (vectorsLoaded);
		timeoutCycles = vectors.size() * (divCycles + 4) + resetCycles + 4;
		repeat (timeoutCycles) @(posedge clk);
		$display("run timed out after %0d cycles", timeoutCycles);
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- src/decodeExecute.sv
`timescale 1ns/1ps

module decodeExecute #(
	parameter int multCycles = 5,
	parameter int divCycles  = 10
) (
	input  logic               clk,
	input  logic               reset,
	input  isaPkg::instrWord   instr,
	input  logic [31:0]        pc,
	input  logic [31:0]        rsData,
	input  logic [31:0]        rtData,
	input  logic [1:0]         addrLow,
	input  logic [31:0]        memRdata,
	output ctrlPkg::ctrlBundle ctrl,
	output logic [31:0]        nextPcOut,
	output logic [3:0]         byteEnable,
	output logic [31:0]        loadData,
	output logic [31:0]        hi,
	output logic [31:0]        lo,
	output logic [31:0]        mduResult,
	output logic               mduBusy
);

	ctrlDecoder decoder0 (
		.instr  (instr),
		.addrLow(addrLow),
		.ctrl   (ctrl)
	);

	nextPc nextPc0 (
		.instr    (instr),
		.pc       (pc),
		.rsData   (rsData),
		.rtData   (rtData),
		.ctrl     (ctrl),
		.nextPcOut(nextPcOut)
	);

	memLaneUnit lanes0 (
		.ctrl      (ctrl),
		.addrLow   (addrLow),
		.memRdata  (memRdata),
		.byteEnable(byteEnable),
		.loadData  (loadData)
	);

	// Multi-cycle unit, the only clocked block
	mulDivUnit #(
		.multCycles(multCycles),
		.divCycles (divCycles)
	) mdu0 (
		.clk      (clk),
		.reset    (reset),
		.ctrl     (ctrl),
		.rsData   (rsData),
		.rtData   (rtData),
		.hi       (hi),
		.lo       (lo),
		.mduResult(mduResult),
		.mduBusy  (mduBusy)
	);

endmodule

//--- src/mulDivUnit.sv
`timescale 1ns/1ps

module mulDivUnit #(
	parameter int multCycles = 5,
	parameter int divCycles  = 10
) (
	input  logic               clk,
	input  logic               reset,
	input  ctrlPkg::ctrlBundle ctrl,
	input  logic [31:0]        rsData,
	input  logic [31:0]        rtData,
	output logic [31:0]        hi,
	output logic [31:0]        lo,
	output logic [31:0]        mduResult,
	output logic               mduBusy
);

	localparam int maxCycles  = (multCycles > divCycles) ? multCycles : divCycles;
	localparam int countWidth = $clog2(maxCycles + 1);

	logic [countWidth-1:0] count;
	logic [31:0]           hiPending;
	logic [31:0]           loPending;
	logic [31:0]           resultHi;
	logic [31:0]           resultLo;
	logic signed [63:0]    prodSigned;
	logic [63:0]           prodUnsigned;
	logic                  isDivide;
	logic                  accept;

	assign prodSigned   = $signed(rsData) * $signed(rtData);
	assign prodUnsigned = rsData * rtData;
	assign isDivide     = (ctrl.mdu == ctrlPkg::mduDiv) || (ctrl.mdu == ctrlPkg::mduDivu);
	assign accept       = ctrl.mduStart && !mduBusy;

	//////////////////////////////////////////////////////////////////////
	// Result of the operation being started
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		resultHi = '0;
		resultLo = '0;
		if (isDivide && rtData == '0) begin
			resultHi = rsData; // Divide by zero
			resultLo = '1;
		end else begin
			case (ctrl.mdu)
				ctrlPkg::mduMult:  {resultHi, resultLo} = prodSigned;
				ctrlPkg::mduMultu: {resultHi, resultLo} = prodUnsigned;
				ctrlPkg::mduDiv: begin
					resultLo = $signed(rsData) / $signed(rtData);
					resultHi = $signed(rsData) % $signed(rtData);
				end
				ctrlPkg::mduDivu: begin
					resultLo = rsData / rtData;
					resultHi = rsData % rtData;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			hiPending <= resultHi;
			loPending <= resultLo;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			hi      <= '0;
			lo      <= '0;
			count   <= '0;
			mduBusy <= 1'b0;
		end else if (mduBusy) begin
			count <= count - 1'b1;
			if (count == countWidth'(1)) begin // Last busy cycle
				mduBusy <= 1'b0;
				hi      <= hiPending;
				lo      <= loPending;
			end
		end else if (ctrl.mduStart) begin
			mduBusy <= 1'b1;
			count   <= isDivide ? countWidth'(divCycles) : countWidth'(multCycles);
		end else if (ctrl.mdu == ctrlPkg::mduMthi) begin
			hi <= rsData;
		end else if (ctrl.mdu == ctrlPkg::mduMtlo) begin
			lo <= rsData;
		end
	end

	assign mduResult = (ctrl.mdu == ctrlPkg::mduMfhi) ? hi
		: (ctrl.mdu == ctrlPkg::mduMflo) ? lo : '0;

	// Pipeline must hold MDU operations while busy
	noStartWhileBusy: assert property (@(posedge clk) disable iff (reset)
		mduBusy |-> !ctrl.mduStart);
	noMoveWhileBusy: assert property (@(posedge clk) disable iff (reset)
		mduBusy |-> !(ctrl.mdu inside {ctrlPkg::mduMthi, ctrlPkg::mduMtlo}));
	busyEndsAtZero: assert property (@(posedge clk) disable iff (reset)
		$fell(mduBusy) |-> (count == '0));

endmodule

//--- src/memLaneUnit.sv
`timescale 1ns/1ps

module memLaneUnit (
	input  ctrlPkg::ctrlBundle ctrl,
	input  logic [1:0]         addrLow,
	input  logic [31:0]        memRdata,
	output logic [3:0]         byteEnable,
	output logic [31:0]        loadData
);

	logic [7:0]  byteSel;
	logic [15:0] halfSel;

	//////////////////////////////////////////////////////////////////////
	// Store lanes
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		byteEnable = 4'b0000;
		if (ctrl.memWrite) begin
			case (ctrl.store)
				ctrlPkg::storeWord: byteEnable = 4'b1111;
				ctrlPkg::storeHalf: byteEnable = addrLow[1] ? 4'b1100 : 4'b0011;
				ctrlPkg::storeByte: byteEnable = 4'b0001 << addrLow;
				default:            byteEnable = 4'b0000;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Load extraction
	//////////////////////////////////////////////////////////////////////
	assign byteSel = memRdata[{addrLow, 3'b000} +: 8];
	assign halfSel = memRdata[{addrLow[1], 4'b0000} +: 16]; // Low bit ignored

	always_comb begin
		case (ctrl.load)
			ctrlPkg::loadWord:        loadData = memRdata;
			ctrlPkg::loadByteSigned:  loadData = {{24{byteSel[7]}}, byteSel};
			ctrlPkg::loadHalfSigned,
			ctrlPkg::loadHalfAligned: loadData = {{16{halfSel[15]}}, halfSel};
			default:                  loadData = '0;
		endcase
	end

endmodule

//--- src/nextPc.sv
`timescale 1ns/1ps

module nextPc (
	input  isaPkg::instrWord   instr,
	input  logic [31:0]        pc,
	input  logic [31:0]        rsData,
	input  logic [31:0]        rtData,
	input  ctrlPkg::ctrlBundle ctrl,
	output logic [31:0]        nextPcOut
);

	logic [31:0] pcPlus4;
	logic [31:0] branchOffset;
	logic [31:0] jumpTarget;
	logic        taken;

	assign pcPlus4 = pc + 32'd4;

	// Word offset, sign extended and scaled
	assign branchOffset = {{14{instr.iType.imm16[15]}}, instr.iType.imm16, 2'b00};

	// Region of the delay slot keeps its top nibble
	assign jumpTarget = {pcPlus4[31:28], instr.jType.index26, 2'b00};

	assign taken = (rsData == rtData) ^ ctrl.cmpNotEqual; // beq or bne

	always_comb begin
		case (ctrl.npc)
			ctrlPkg::npcBranch: begin
				if (taken)
					nextPcOut = pcPlus4 + branchOffset;
				else
					nextPcOut = pcPlus4;
			end
			ctrlPkg::npcJump:    nextPcOut = jumpTarget;
			ctrlPkg::npcJumpReg: nextPcOut = rsData;
			default:             nextPcOut = pcPlus4;
		endcase
	end

endmodule

//--- src/ctrlDecoder.sv
`timescale 1ns/1ps

module ctrlDecoder (
	input  isaPkg::instrWord  instr,
	input  logic [1:0]        addrLow,
	output ctrlPkg::ctrlBundle ctrl
);

	wire [5:0] op = instr.rType.op;
	wire [5:0] fn = instr.rType.func;

	//////////////////////////////////////////////////////////////////////
	// One flag per instruction
	//////////////////////////////////////////////////////////////////////
	wire isR     = (op == isaPkg::opRType);
	wire isAdd   = isR && (fn == isaPkg::fnAdd);
	wire isSub   = isR && (fn == isaPkg::fnSub);
	wire isAnd   = isR && (fn == isaPkg::fnAnd);
	wire isOr    = isR && (fn == isaPkg::fnOr);
	wire isSlt   = isR && (fn == isaPkg::fnSlt);
	wire isSltu  = isR && (fn == isaPkg::fnSltu);
	wire isJr    = isR && (fn == isaPkg::fnJr);
	wire isMult  = isR && (fn == isaPkg::fnMult);
	wire isMultu = isR && (fn == isaPkg::fnMultu);
	wire isDiv   = isR && (fn == isaPkg::fnDiv);
	wire isDivu  = isR && (fn == isaPkg::fnDivu);
	wire isMfhi  = isR && (fn == isaPkg::fnMfhi);
	wire isMflo  = isR && (fn == isaPkg::fnMflo);
	wire isMthi  = isR && (fn == isaPkg::fnMthi);
	wire isMtlo  = isR && (fn == isaPkg::fnMtlo);

	wire isAddi = (op == isaPkg::opAddi);
	wire isAndi = (op == isaPkg::opAndi);
	wire isOri  = (op == isaPkg::opOri);
	wire isLui  = (op == isaPkg::opLui);
	wire isLw   = (op == isaPkg::opLw);
	wire isLb   = (op == isaPkg::opLb);
	wire isLh   = (op == isaPkg::opLh);
	wire isLhs  = (op == isaPkg::opLhs);
	wire isSw   = (op == isaPkg::opSw);
	wire isSb   = (op == isaPkg::opSb);
	wire isSh   = (op == isaPkg::opSh);
	wire isBeq  = (op == isaPkg::opBeq);
	wire isBne  = (op == isaPkg::opBne);
	wire isJ    = (op == isaPkg::opJ);
	wire isJal  = (op == isaPkg::opJal);

	wire rdForm  = isAdd | isSub | isAnd | isOr | isSlt | isSltu | isMfhi | isMflo;
	wire isLoad  = isLw | isLb | isLh | isLhs;
	wire isStore = isSw | isSb | isSh;
	wire lhsOk   = isLhs && !addrLow[0]; // Offset 0 or 2 only

	always_comb begin
		ctrl.regDst = isJal ? ctrlPkg::regDstRa : rdForm ? ctrlPkg::regDstRd : ctrlPkg::regDstRt;
		ctrl.regWrite = rdForm | isAddi | isAndi | isOri | isLui | isJal
			| isLw | isLb | isLh | lhsOk;
		ctrl.extSigned = isLoad | isStore | isAddi;
		ctrl.aluSrcImm = isLoad | isStore | isAddi | isAndi | isOri | isLui;

		if (isSub) ctrl.alu = ctrlPkg::aluSub;
		else if (isOr | isOri) ctrl.alu = ctrlPkg::aluOr;
		else if (isAnd | isAndi) ctrl.alu = ctrlPkg::aluAnd;
		else if (isLui) ctrl.alu = ctrlPkg::aluLui;
		else if (isSlt) ctrl.alu = ctrlPkg::aluSlt;
		else if (isSltu) ctrl.alu = ctrlPkg::aluSltu;
		else ctrl.alu = ctrlPkg::aluAdd;

		ctrl.memWrite = isStore;
		ctrl.memToReg = isJal ? ctrlPkg::wbLink : isLoad ? ctrlPkg::wbMem : ctrlPkg::wbAlu;

		if (isBeq | isBne) ctrl.npc = ctrlPkg::npcBranch;
		else if (isJ | isJal) ctrl.npc = ctrlPkg::npcJump;
		else if (isJr) ctrl.npc = ctrlPkg::npcJumpReg;
		else ctrl.npc = ctrlPkg::npcSeq;
		ctrl.cmpNotEqual = isBne;

		ctrl.store = isSw ? ctrlPkg::storeWord : isSh ? ctrlPkg::storeHalf
			: isSb ? ctrlPkg::storeByte : ctrlPkg::storeNone;

		if (isLw) ctrl.load = ctrlPkg::loadWord;
		else if (isLb) ctrl.load = ctrlPkg::loadByteSigned;
		else if (isLh) ctrl.load = ctrlPkg::loadHalfSigned;
		else if (isLhs) ctrl.load = ctrlPkg::loadHalfAligned;
		else ctrl.load = ctrlPkg::loadNone;

		ctrl.mduStart = isMult | isMultu | isDiv | isDivu;
		ctrl.selMdu = isMfhi | isMflo;

		if (isMult) ctrl.mdu = ctrlPkg::mduMult;
		else if (isMultu) ctrl.mdu = ctrlPkg::mduMultu;
		else if (isDiv) ctrl.mdu = ctrlPkg::mduDiv;
		else if (isDivu) ctrl.mdu = ctrlPkg::mduDivu;
		else if (isMfhi) ctrl.mdu = ctrlPkg::mduMfhi;
		else if (isMflo) ctrl.mdu = ctrlPkg::mduMflo;
		else if (isMthi) ctrl.mdu = ctrlPkg::mduMthi;
		else if (isMtlo) ctrl.mdu = ctrlPkg::mduMtlo;
		else ctrl.mdu = ctrlPkg::mduNone;
	end

	// A store never writes the register file
	storeNoRegWrite: assert final (!(ctrl.memWrite && ctrl.regWrite));

endmodule

//--- src/ctrlPkg.sv
package ctrlPkg;

	typedef enum logic [1:0] {
		npcSeq     = 2'b00,
		npcJump    = 2'b01, // j and jal
		npcBranch  = 2'b10,
		npcJumpReg = 2'b11
	} npcOp;

	typedef enum logic [2:0] {
		aluAdd  = 3'b000,
		aluSub  = 3'b001,
		aluOr   = 3'b010,
		aluAnd  = 3'b011,
		aluLui  = 3'b100,
		aluSlt  = 3'b101,
		aluSltu = 3'b110
	} aluCtrl;

	// Nine operations, hence four bits
	typedef enum logic [3:0] {
		mduNone, mduMult, mduMultu, mduDiv, mduDivu,
		mduMfhi, mduMflo, mduMthi, mduMtlo
	} mduOp;

	typedef enum logic [1:0] {
		storeWord = 2'b00,
		storeHalf = 2'b01,
		storeByte = 2'b10,
		storeNone = 2'b11
	} storeWidth;

	typedef enum logic [2:0] {
		loadWord        = 3'b000,
		loadByteSigned  = 3'b010,
		loadHalfSigned  = 3'b100,
		loadHalfAligned = 3'b101,
		loadNone        = 3'b111
	} loadKind;

	typedef enum logic [1:0] {regDstRt, regDstRd, regDstRa} regDstSel;
	typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSel;

	//////////////////////////////////////////////////////////////////////
	// Control bundle carried to the later stages
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		regDstSel  regDst;
		logic      regWrite;
		logic      extSigned; // Sign extension of imm16
		logic      aluSrcImm;
		aluCtrl    alu;
		logic      memWrite;
		wbSel      memToReg;
		npcOp      npc;
		logic      cmpNotEqual;
		storeWidth store;
		loadKind   load;
		logic      mduStart;
		logic      selMdu; // Write back from HI/LO
		mduOp      mdu;
	} ctrlBundle;

endpackage

//--- src/isaPkg.sv
package isaPkg;

	//////////////////////////////////////////////////////////////////////
	// Primary opcodes
	//////////////////////////////////////////////////////////////////////
	localparam logic [5:0] opRType = 6'b000000;
	localparam logic [5:0] opJ     = 6'b000010;
	localparam logic [5:0] opJal   = 6'b000011;
	localparam logic [5:0] opBeq   = 6'b000100;
	localparam logic [5:0] opBne   = 6'b000101;
	localparam logic [5:0] opAddi  = 6'b001000;
	localparam logic [5:0] opAndi  = 6'b001100;
	localparam logic [5:0] opOri   = 6'b001101;
	localparam logic [5:0] opLui   = 6'b001111;
	localparam logic [5:0] opLb    = 6'b100000;
	localparam logic [5:0] opLh    = 6'b100001;
	localparam logic [5:0] opLw    = 6'b100011;
	localparam logic [5:0] opLhs   = 6'b100100; // Aligned-only signed halfword load
	localparam logic [5:0] opSb    = 6'b101000;
	localparam logic [5:0] opSh    = 6'b101001;
	localparam logic [5:0] opSw    = 6'b101011;

	// Function codes under opRType
	localparam logic [5:0] fnJr    = 6'b001000;
	localparam logic [5:0] fnMfhi  = 6'b010000;
	localparam logic [5:0] fnMthi  = 6'b010001;
	localparam logic [5:0] fnMflo  = 6'b010010;
	localparam logic [5:0] fnMtlo  = 6'b010011;
	localparam logic [5:0] fnMult  = 6'b011000;
	localparam logic [5:0] fnMultu = 6'b011001;
	localparam logic [5:0] fnDiv   = 6'b011010;
	localparam logic [5:0] fnDivu  = 6'b011011;
	localparam logic [5:0] fnAdd   = 6'b100000;
	localparam logic [5:0] fnSub   = 6'b100010;
	localparam logic [5:0] fnAnd   = 6'b100100;
	localparam logic [5:0] fnOr    = 6'b100101;
	localparam logic [5:0] fnSlt   = 6'b101010;
	localparam logic [5:0] fnSltu  = 6'b101011;

	//////////////////////////////////////////////////////////////////////
	// Instruction word and its three field layouts
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] func;
	} rTypeFields;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} iTypeFields;

	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] index26;
	} jTypeFields;

	typedef union packed {
		rTypeFields rType;
		iTypeFields iType;
		jTypeFields jType;
	} instrWord;

endpackage
